//--- design/fp_config.svh
// FP_SIZE must be 32 or 64; the exponent and mantissa widths and the bias all follow from it
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// total width of an operand, 32 for single precision and 64 for double
`define FP_SIZE 32

// exponent field width
`define FP_EXP_W ((`FP_SIZE == 64) ? 11 : 8)

// stored mantissa width, the hidden bit is not counted
`define FP_MANT_W ((`FP_SIZE == 64) ? 52 : 23)

// exponent bias, twice the bias plus one is the all-ones infinity/NaN code
`define FP_BIAS ((`FP_SIZE == 64) ? 1023 : 127)

`endif

//--- design/fp_format_pkg.sv
// number and operation types; the canonical NaN width follows FP_SIZE from fp_config.svh
`default_nettype none

`include "fp_config.svh"

package fp_format_pkg;

  // rounding mode codes as carried on the rm port, unknown codes round to nearest even
  typedef enum logic [2:0] {
    RTE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } fp_op_e;

  // subnormal encodings are classified as zero
  typedef enum logic [1:0] {
    CLS_NORMAL,
    CLS_ZERO,
    CLS_INF,
    CLS_NAN
  } fp_class_e;

  // positive quiet NaN with only the quiet bit set in the mantissa
  localparam logic [`FP_SIZE-1:0] QNAN =
    {1'b0, {`FP_EXP_W{1'b1}}, 1'b1, {(`FP_MANT_W-1){1'b0}}};

endpackage

`default_nettype wire

//--- design/fp_ctrl_pkg.sv
// sequencing types shared by the FSM, the datapath units and the result register
`default_nettype none

package fp_ctrl_pkg;

  // one state per stage, each unit registers its outputs in its own state
  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_ALIGN     = 3'd1,
    S_ADD       = 3'd2,
    S_NORMALIZE = 3'd3,
    S_ROUNDING  = 3'd4
  } fp_state_e;

  // exception flags reported with every result
  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

endpackage

`default_nettype wire

//--- design/cla_adder.sv
// purely combinational; c_o is the carry out, and with sub set it means no borrow occurred
`timescale 1ns/10ps
`default_nettype none

module cla_adder #(
  parameter int InputSize = 24
) (
  input  wire  [InputSize-1:0] a,
  input  wire  [InputSize-1:0] b,
  input  wire                  sub,
  output logic                 c_o,
  output logic [InputSize-1:0] s
);

  // the operands are padded up to whole four-bit groups
  localparam int Groups = (InputSize + 3) / 4;
  localparam int Padded = Groups * 4;

  logic [Padded-1:0] g;
  logic [Padded-1:0] p;
  logic [Padded:0]   c;
  logic [Groups-1:0] grp_g;
  logic [Groups-1:0] grp_p;

  always_comb begin
    // subtraction adds the inverted b with a carry in of one
    g = {Padded{1'b0}};
    p = {Padded{1'b0}};
    g[InputSize-1:0] = a & (b ^ {InputSize{sub}});
    p[InputSize-1:0] = a ^ (b ^ {InputSize{sub}});
    c[0] = sub;
    for (int i = 0; i < Groups; i++) begin
      // group generate and propagate feed the carry into the next group
      grp_g[i] = g[4*i+3] | (p[4*i+3] & g[4*i+2]) | (p[4*i+3] & p[4*i+2] & g[4*i+1])
               | (p[4*i+3] & p[4*i+2] & p[4*i+1] & g[4*i]);
      grp_p[i] = &p[4*i +: 4];
      c[4*i+1] = g[4*i] | (p[4*i] & c[4*i]);
      c[4*i+2] = g[4*i+1] | (p[4*i+1] & g[4*i]) | (p[4*i+1] & p[4*i] & c[4*i]);
      c[4*i+3] = g[4*i+2] | (p[4*i+2] & g[4*i+1]) | (p[4*i+2] & p[4*i+1] & g[4*i])
               | (p[4*i+2] & p[4*i+1] & p[4*i] & c[4*i]);
      c[4*i+4] = grp_g[i] | (grp_p[i] & c[4*i]);
    end
    // padding bits never generate, so c at InputSize is the true carry out
    s   = p[InputSize-1:0] ^ c[InputSize-1:0];
    c_o = c[InputSize];
  end

endmodule

`default_nettype wire

//--- design/rounding.sv
// combinational; the three low input bits are guard, round and sticky, unknown modes act as RTE
`timescale 1ns/10ps
`default_nettype none

`include "fp_config.svh"

module rounding (
  input  wire fp_format_pkg::round_mode_e rounding_mode,
  input  wire                             real_sign,
  input  wire [`FP_MANT_W+3:0]            mant_normalized,
  output logic                            carry_rounding,
  output logic                            is_zero,
  output logic [`FP_MANT_W:0]             mant_final
);
  import fp_format_pkg::*;

  logic                is_halfway;
  logic                carry;
  logic                round_up;
  logic [`FP_MANT_W:0] mant_truncated;
  logic [`FP_MANT_W:0] mant_rounded_up;

  // nothing is dropped when guard, round and sticky are all clear
  assign is_zero = ~|mant_normalized[2:0];

  // exactly half an ulp, only the guard bit is set
  assign is_halfway = mant_normalized[2] & ~|mant_normalized[1:0];

  assign mant_truncated = mant_normalized[`FP_MANT_W+3:3];

  // the incremented candidate, its carry moves the exponent up by one
  cla_adder #(.InputSize(`FP_MANT_W + 1)) u_inc (
    .a   (mant_normalized[`FP_MANT_W+3:3]),
    .b   ({{`FP_MANT_W{1'b0}}, 1'b1}),
    .sub (1'b0),
    .c_o (carry),
    .s   (mant_rounded_up)
  );

  always_comb begin
    case (rounding_mode)
      RTZ: begin
        round_up = 1'b0;
      end
      RDN: begin
        // a negative magnitude grows towards minus infinity
        round_up = real_sign & ~is_zero;
      end
      RUP: begin
        round_up = ~real_sign & ~is_zero;
      end
      RMM: begin
        // ties go away from zero, so the guard bit alone decides
        round_up = mant_normalized[2];
      end
      default: begin
        // nearest, ties go to the even neighbour
        round_up = is_halfway ? mant_normalized[3] : mant_normalized[2];
      end
    endcase
    {carry_rounding, mant_final} = round_up ? {carry, mant_rounded_up} : {1'b0, mant_truncated};
  end

endmodule

`default_nettype wire

//--- design/exp_sign_unit.sv
// operands are sampled on the start edge; subnormal inputs count as zero, any NaN yields QNAN
`timescale 1ns/10ps
`default_nettype none

`include "fp_config.svh"

module exp_sign_unit (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire fp_ctrl_pkg::fp_state_e     state,
  input  wire fp_format_pkg::fp_op_e      op,
  input  wire fp_format_pkg::round_mode_e rm,
  input  wire [`FP_SIZE-1:0]              a,
  input  wire [`FP_SIZE-1:0]              b,
  output logic                            swap,
  output logic [`FP_EXP_W-1:0]            exp_diff,
  output logic [`FP_EXP_W-1:0]            exp_large,
  output logic                            res_sign,
  output logic                            special_valid,
  output logic [`FP_SIZE-1:0]             special_result,
  output logic                            invalid
);
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;

  logic [`FP_SIZE-1:0]  a_q;
  logic [`FP_SIZE-1:0]  b_q;
  fp_op_e               op_q;
  round_mode_e          rm_q;
  fp_class_e            cls_a;
  fp_class_e            cls_b;
  logic                 sign_a;
  logic                 sign_b;
  logic                 eff_sub;
  logic                 b_gt_a;
  logic                 zero_sign;
  logic                 snan;
  logic [`FP_SIZE-2:0]  mag_a;
  logic [`FP_SIZE-2:0]  mag_b;
  logic                 spec_v_d;
  logic                 inv_d;
  logic [`FP_SIZE-1:0]  spec_d;

  function automatic fp_class_e classify(input logic [`FP_SIZE-1:0] x);
    fp_class_e cls;
    if (&x[`FP_SIZE-2 -: `FP_EXP_W])
      cls = (|x[`FP_MANT_W-1:0]) ? CLS_NAN : CLS_INF;
    else if (x[`FP_SIZE-2 -: `FP_EXP_W] == '0)
      cls = CLS_ZERO;
    else
      cls = CLS_NORMAL;
    return cls;
  endfunction

  always_comb begin
    // b takes the operation into its sign, so the rest only sees an addition
    sign_a    = a_q[`FP_SIZE-1];
    sign_b    = b_q[`FP_SIZE-1] ^ (op_q == OP_SUB);
    mag_a     = a_q[`FP_SIZE-2:0];
    mag_b     = b_q[`FP_SIZE-2:0];
    cls_a     = classify(a_q);
    cls_b     = classify(b_q);
    eff_sub   = sign_a ^ sign_b;
    b_gt_a    = mag_b > mag_a;
    // an exactly cancelling sum is +0 except when rounding down
    zero_sign = (rm_q == RDN);
    // signaling NaN has the quiet bit clear
    snan = (cls_a == CLS_NAN && !a_q[`FP_MANT_W-1]) || (cls_b == CLS_NAN && !b_q[`FP_MANT_W-1]);

    spec_v_d = 1'b1;
    inv_d    = 1'b0;
    spec_d   = {sign_a, mag_a};
    if (cls_a == CLS_NAN || cls_b == CLS_NAN) begin
      spec_d = QNAN;
      inv_d  = snan;
    end else if (cls_a == CLS_INF && cls_b == CLS_INF) begin
      // opposite infinities cancel into an invalid operation
      spec_d = eff_sub ? QNAN : {sign_a, mag_a};
      inv_d  = eff_sub;
    end else if (cls_a == CLS_INF) begin
      spec_d = {sign_a, mag_a};
    end else if (cls_b == CLS_INF) begin
      spec_d = {sign_b, mag_b};
    end else if (cls_a == CLS_ZERO && cls_b == CLS_ZERO) begin
      spec_d = {eff_sub ? zero_sign : sign_a, {(`FP_SIZE-1){1'b0}}};
    end else if (cls_a == CLS_ZERO) begin
      spec_d = {sign_b, mag_b};
    end else if (cls_b == CLS_ZERO) begin
      spec_d = {sign_a, mag_a};
    end else begin
      spec_v_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    // the last idle cycle is the start cycle, so this holds the started operands
    if (state == S_IDLE) begin
      a_q  <= a;
      b_q  <= b;
      op_q <= op;
      rm_q <= rm;
    end
    if (state == S_ALIGN) begin
      swap           <= b_gt_a;
      exp_large      <= b_gt_a ? b_q[`FP_SIZE-2 -: `FP_EXP_W] : a_q[`FP_SIZE-2 -: `FP_EXP_W];
      exp_diff       <= b_gt_a ? b_q[`FP_SIZE-2 -: `FP_EXP_W] - a_q[`FP_SIZE-2 -: `FP_EXP_W]
                               : a_q[`FP_SIZE-2 -: `FP_EXP_W] - b_q[`FP_SIZE-2 -: `FP_EXP_W];
      res_sign       <= (eff_sub && mag_a == mag_b) ? zero_sign : (b_gt_a ? sign_b : sign_a);
      special_result <= spec_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      special_valid <= 1'b0;
      invalid       <= 1'b0;
    end else if (state == S_ALIGN) begin
      special_valid <= spec_v_d;
      invalid       <= inv_d;
    end
  end

endmodule

`default_nettype wire

//--- design/mant_path.sv
// works on restored hidden bits only; zero, infinity and NaN operands are resolved elsewhere
`timescale 1ns/10ps
`default_nettype none

`include "fp_config.svh"

module mant_path (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire fp_ctrl_pkg::fp_state_e state,
  input  wire fp_format_pkg::fp_op_e  op,
  input  wire [`FP_SIZE-1:0]          a,
  input  wire [`FP_SIZE-1:0]          b,
  input  wire                         swap,
  input  wire [`FP_EXP_W-1:0]         exp_diff,
  output logic [`FP_MANT_W+3:0]       mant_normalized,
  output logic [`FP_EXP_W-1:0]        norm_shift,
  output logic                        norm_up,
  output logic                        mant_zero
);
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;

  // hidden bit, mantissa, then guard, round and sticky
  localparam int W  = `FP_MANT_W + 4;
  localparam int EW = `FP_EXP_W;

  logic [`FP_MANT_W-1:0] mant_a_q;
  logic [`FP_MANT_W-1:0] mant_b_q;
  logic                  eff_sub_q;
  logic [W-1:0]          large_m;
  logic [W-1:0]          small_m;
  logic [W-1:0]          shifted;
  logic [W-1:0]          aligned;
  logic                  sticky;
  logic [W-1:0]          adder_s;
  logic                  adder_c;
  logic [W:0]            sum_q;
  logic [EW-1:0]         lz;
  logic                  found;

  always_comb begin
    large_m = swap ? {1'b1, mant_b_q, 3'b000} : {1'b1, mant_a_q, 3'b000};
    small_m = swap ? {1'b1, mant_a_q, 3'b000} : {1'b1, mant_b_q, 3'b000};
    shifted = small_m >> exp_diff;
    // every bit pushed past the low end is folded into the sticky position
    sticky  = |(small_m & ~({W{1'b1}} << exp_diff));
    aligned = {shifted[W-1:1], shifted[0] | sticky};
  end

  // the larger magnitude is always on a, so subtraction never goes negative
  cla_adder #(.InputSize(W)) u_mant_add (
    .a   (large_m),
    .b   (aligned),
    .sub (eff_sub_q),
    .c_o (adder_c),
    .s   (adder_s)
  );

  // leading zero count over the sum below the carry bit
  always_comb begin
    lz    = '0;
    found = 1'b0;
    for (int i = W - 1; i >= 0; i--) begin
      if (!found && sum_q[i]) begin
        lz    = EW'(W - 1 - i);
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      mant_a_q  <= a[`FP_MANT_W-1:0];
      mant_b_q  <= b[`FP_MANT_W-1:0];
      eff_sub_q <= a[`FP_SIZE-1] ^ b[`FP_SIZE-1] ^ (op == OP_SUB);
    end
    // the carry out of a subtraction only says there was no borrow
    if (state == S_ADD)
      sum_q <= {adder_c & ~eff_sub_q, adder_s};
    if (state == S_NORMALIZE) begin
      norm_shift      <= sum_q[W] ? '0 : lz;
      mant_normalized <= sum_q[W] ? {sum_q[W:2], sum_q[1] | sum_q[0]} : sum_q[W-1:0] << lz;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      norm_up   <= 1'b0;
      mant_zero <= 1'b0;
    end else if (state == S_NORMALIZE) begin
      norm_up   <= sum_q[W];
      mant_zero <= (sum_q == '0);
    end
  end

  // the packer takes the hidden bit from the top of a nonzero normalized mantissa
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_ROUNDING && !mant_zero) |-> mant_normalized[W-1]);

endmodule

`default_nettype wire

//--- design/result_packer.sv
// overflow always gives infinity and underflow flushes to signed zero, whatever the rounding mode
`timescale 1ns/10ps
`default_nettype none

`include "fp_config.svh"

module result_packer (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire fp_ctrl_pkg::fp_state_e     state,
  input  wire [`FP_EXP_W-1:0]             exp_large,
  input  wire                             res_sign,
  input  wire [`FP_EXP_W-1:0]             norm_shift,
  input  wire                             norm_up,
  input  wire                             mant_zero,
  input  wire [`FP_MANT_W+3:0]            mant_normalized,
  input  wire fp_format_pkg::round_mode_e rm,
  input  wire                             special_valid,
  input  wire [`FP_SIZE-1:0]              special_result,
  input  wire                             invalid,
  output logic [`FP_SIZE-1:0]             result,
  output fp_ctrl_pkg::fp_flags_t          flags
);
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;

  localparam int EW = `FP_EXP_W;

  round_mode_e         rm_q;
  logic                carry_rounding;
  logic                is_zero;
  logic [`FP_MANT_W:0] mant_final;
  logic [EW+1:0]       exp_final;
  logic                overflow;
  logic                underflow;

  rounding u_rounding (
    .rounding_mode   (rm_q),
    .real_sign       (res_sign),
    .mant_normalized (mant_normalized),
    .carry_rounding  (carry_rounding),
    .is_zero         (is_zero),
    .mant_final      (mant_final)
  );

  always_comb begin
    // two spare bits keep the sign of an exponent that went below one
    exp_final = {2'b00, exp_large} + {{(EW+1){1'b0}}, norm_up}
              + {{(EW+1){1'b0}}, carry_rounding} - {2'b00, norm_shift};
    underflow = exp_final[EW+1] | (exp_final == '0);
    overflow  = ~exp_final[EW+1] & (exp_final > (EW+2)'(2 * `FP_BIAS));
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE)
      rm_q <= rm;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
      flags  <= '0;
    end else if (state == S_ROUNDING) begin
      flags <= '0;
      if (special_valid) begin
        result        <= special_result;
        flags.invalid <= invalid;
      end else if (mant_zero) begin
        result <= {res_sign, {(`FP_SIZE-1){1'b0}}};
      end else if (overflow) begin
        result         <= {res_sign, {EW{1'b1}}, {`FP_MANT_W{1'b0}}};
        flags.overflow <= 1'b1;
        flags.inexact  <= ~is_zero;
      end else if (underflow) begin
        result          <= {res_sign, {(`FP_SIZE-1){1'b0}}};
        flags.underflow <= 1'b1;
        flags.inexact   <= ~is_zero;
      end else begin
        // the hidden bit of mant_final is implied and not stored
        result        <= {res_sign, exp_final[EW-1:0], mant_final[`FP_MANT_W-1:0]};
        flags.inexact <= ~is_zero;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/fp_sequencer.sv
// one operation at a time; start is ignored while busy, done pulses once per operation
`timescale 1ns/10ps
`default_nettype none

module fp_sequencer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     start,
  output fp_ctrl_pkg::fp_state_e  state,
  output logic                    busy,
  output logic                    done
);
  import fp_ctrl_pkg::*;

  fp_state_e state_next;

  always_comb begin
    case (state)
      S_IDLE:      state_next = start ? S_ALIGN : S_IDLE;
      S_ALIGN:     state_next = S_ADD;
      S_ADD:       state_next = S_NORMALIZE;
      S_NORMALIZE: state_next = S_ROUNDING;
      default:     state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      // done rises together with the packed result
      done  <= (state == S_ROUNDING);
    end
  end

  assign busy = (state != S_IDLE);

  // the sequence visits S_ROUNDING once, so done cannot repeat
  assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

  assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_IDLE && !start) |=> (state == S_IDLE));

endmodule

`default_nettype wire

//--- design/fp_add_sub.sv
// inputs are sampled on the start edge, result and flags hold from done until the next done
`timescale 1ns/10ps
`default_nettype none

`include "fp_config.svh"

module fp_add_sub (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             start,
  input  wire fp_format_pkg::fp_op_e      op,
  input  wire fp_format_pkg::round_mode_e rm,
  input  wire [`FP_SIZE-1:0]              a,
  input  wire [`FP_SIZE-1:0]              b,
  output logic [`FP_SIZE-1:0]             result,
  output fp_ctrl_pkg::fp_flags_t          flags,
  output logic                            busy,
  output logic                            done
);
  import fp_ctrl_pkg::*;

  fp_state_e             state;
  logic                  swap;
  logic [`FP_EXP_W-1:0]  exp_diff;
  logic [`FP_EXP_W-1:0]  exp_large;
  logic                  res_sign;
  logic                  special_valid;
  logic [`FP_SIZE-1:0]   special_result;
  logic                  invalid;
  logic [`FP_MANT_W+3:0] mant_normalized;
  logic [`FP_EXP_W-1:0]  norm_shift;
  logic                  norm_up;
  logic                  mant_zero;

  fp_sequencer u_seq (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .state (state),
    .busy  (busy),
    .done  (done)
  );

  // exponent and sign half, registers in S_ALIGN
  exp_sign_unit u_exp (
    .clk            (clk),
    .rst_n          (rst_n),
    .state          (state),
    .op             (op),
    .rm             (rm),
    .a              (a),
    .b              (b),
    .swap           (swap),
    .exp_diff       (exp_diff),
    .exp_large      (exp_large),
    .res_sign       (res_sign),
    .special_valid  (special_valid),
    .special_result (special_result),
    .invalid        (invalid)
  );

  // mantissa half, adds in S_ADD and normalizes in S_NORMALIZE
  mant_path u_mant (
    .clk             (clk),
    .rst_n           (rst_n),
    .state           (state),
    .op              (op),
    .a               (a),
    .b               (b),
    .swap            (swap),
    .exp_diff        (exp_diff),
    .mant_normalized (mant_normalized),
    .norm_shift      (norm_shift),
    .norm_up         (norm_up),
    .mant_zero       (mant_zero)
  );

  result_packer u_pack (
    .clk             (clk),
    .rst_n           (rst_n),
    .state           (state),
    .exp_large       (exp_large),
    .res_sign        (res_sign),
    .norm_shift      (norm_shift),
    .norm_up         (norm_up),
    .mant_zero       (mant_zero),
    .mant_normalized (mant_normalized),
    .rm              (rm),
    .special_valid   (special_valid),
    .special_result  (special_result),
    .invalid         (invalid),
    .result          (result),
    .flags           (flags)
  );

endmodule

`default_nettype wire

//--- testbench/fp_add_sub_tb.sv
// needs FP_SIZE 32 since the vector file holds single precision values; run from the project root
`timescale 1ns/10ps
`default_nettype none

`include "fp_config.svh"

module fp_add_sub_tb;
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;

  // cycles allowed between the start edge and done before the run is abandoned
  localparam int timeout_cycles = 20;

  logic                clk;
  logic                rst_n;
  logic                start;
  fp_op_e              op;
  round_mode_e         rm;
  logic [`FP_SIZE-1:0] a;
  logic [`FP_SIZE-1:0] b;
  logic [`FP_SIZE-1:0] result;
  fp_flags_t           flags;
  logic                busy;
  logic                done;

  int          seed;
  int          fd;
  int          code;
  int          n_vec;
  logic        reading;
  // one vector line holds op, mode, a, b, expected result and expected flags in hex
  logic [31:0] v_op;
  logic [31:0] v_rm;
  logic [31:0] v_a;
  logic [31:0] v_b;
  logic [31:0] v_res;
  logic [31:0] v_flags;

  fp_add_sub uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .op     (op),
    .rm     (rm),
    .a      (a),
    .b      (b),
    .result (result),
    .flags  (flags),
    .busy   (busy),
    .done   (done)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare(input logic [63:0] got, input logic [63:0] expected, input string what);
    if (got !== expected)
      abort_run($sformatf("[ERROR] time %0t: %s, got %h, expected %h",
                          $time, what, got, expected));
  endtask

  // random start pulses land only while the FSM is past idle, with garbage operands alongside
  task automatic stray_start(input int edges_after);
    logic [31:0] r;
    r = $random(seed);
    if (edges_after < 4 && r[0]) begin
      start <= 1'b1;
      a     <= $random(seed);
      b     <= $random(seed);
    end else begin
      start <= 1'b0;
    end
  endtask

  // called just after the start edge, returns how many edges later done was seen
  task automatic wait_done(output int edges_after);
    edges_after = 0;
    @(negedge clk);
    while (done !== 1'b1) begin
      compare(busy, 1, "busy while the operation runs");
      if (edges_after >= timeout_cycles)
        abort_run("done never arrived within the timeout");
      @(posedge clk);
      edges_after++;
      stray_start(edges_after);
      @(negedge clk);
    end
  endtask

  task automatic run_vector(input int idx, input logic [31:0] t_op, input logic [31:0] t_rm,
                            input logic [31:0] t_a, input logic [31:0] t_b,
                            input logic [31:0] t_res, input logic [31:0] t_flags);
    int edges_after;
    // drive the operation and a one-cycle start
    @(posedge clk);
    op    <= fp_op_e'(t_op[0]);
    rm    <= round_mode_e'(t_rm[2:0]);
    a     <= t_a;
    b     <= t_b;
    start <= 1'b1;
    // the DUT samples start on this edge
    @(posedge clk);
    stray_start(0);
    wait_done(edges_after);
    compare(edges_after, 4, $sformatf("vector %0d edges from start to done", idx));
    compare(busy, 0, $sformatf("vector %0d busy in the done cycle", idx));
    compare(result, t_res, $sformatf("vector %0d result", idx));
    compare(flags, t_flags[3:0], $sformatf("vector %0d flags", idx));
    // done is a single-cycle pulse and the result stays put afterwards
    @(negedge clk);
    compare(done, 0, $sformatf("vector %0d done after its pulse", idx));
    compare(result, t_res, $sformatf("vector %0d result held after done", idx));
    compare(flags, t_flags[3:0], $sformatf("vector %0d flags held after done", idx));
  endtask

  task automatic check_reset();
    compare(busy, 0, "busy after reset");
    compare(done, 0, "done after reset");
    compare(result, 0, "result after reset");
    compare(flags, 0, "flags after reset");
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    op    = OP_ADD;
    rm    = RTE;
    a     = '0;
    b     = '0;
    seed  = 77;
    n_vec = 0;

    if (`FP_SIZE != 32)
      abort_run("the vector file holds single precision values but FP_SIZE is not 32");

    // reset is held low over three rising edges
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset();

    fd = $fopen("testbench/fp_add_sub_input.txt", "r");
    if (fd == 0)
      abort_run("could not open testbench/fp_add_sub_input.txt");

    reading = 1'b1;
    while (reading) begin
      code = $fscanf(fd, "%h %h %h %h %h %h\n", v_op, v_rm, v_a, v_b, v_res, v_flags);
      if (code == 6) begin
        n_vec++;
        run_vector(n_vec, v_op, v_rm, v_a, v_b, v_res, v_flags);
      end else if ($feof(fd)) begin
        reading = 1'b0;
      end else begin
        abort_run($sformatf("line %0d of the vector file is malformed", n_vec + 1));
      end
    end
    $fclose(fd);

    if (n_vec == 0) begin
      abort_run("the vector file held no vectors");
    end else begin
      $display("%0d vectors checked", n_vec);
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- fp_add_sub.f
+incdir+design
design/fp_format_pkg.sv
design/fp_ctrl_pkg.sv
design/cla_adder.sv
design/rounding.sv
design/exp_sign_unit.sv
design/mant_path.sv
design/result_packer.sv
design/fp_sequencer.sv
design/fp_add_sub.sv
testbench/fp_add_sub_tb.sv

//--- testbench/fp_add_sub_input.txt
0 0 3F800000 33800000 3F800000 1
0 0 3F800001 33800000 3F800002 1
0 4 3F800000 33800000 3F800001 1
0 0 3F800000 33C00000 3F800001 1
0 1 3F800000 33C00000 3F800000 1
0 2 3F800000 33C00000 3F800000 1
0 3 3F800000 33000000 3F800001 1
0 4 3F800000 33000000 3F800000 1
0 0 BF800000 B3800000 BF800000 1
0 2 BF800000 B3000000 BF800001 1
0 3 BF800000 B3C00000 BF800000 1
0 4 BF800000 B3800000 BF800001 1
0 1 BF800000 B3C00000 BF800000 1
0 0 3FC00000 3EC00000 3FF00000 0
0 0 40400000 40A00000 41000000 0
1 0 3F800001 3F800000 34000000 0
1 0 3F800000 3F800001 B4000000 0
0 0 3FFFFFFF 33800000 40000000 1
0 0 FFC12345 3F800000 7FC00000 0
0 0 3F800000 7F800001 7FC00000 8
1 0 7F800000 7F800000 7FC00000 8
0 0 FF800000 3F800000 FF800000 0
0 0 00000001 3F800000 3F800000 0
1 0 40490FDB 40490FDB 00000000 0
1 2 40490FDB 40490FDB 80000000 0
0 0 7F7FFFFF 7F7FFFFF 7F800000 4
0 1 FF7FFFFF FF7FFFFF FF800000 4
1 0 00800001 00800000 00000000 2
1 3 80800001 80800000 80000000 2
